/* Makefile */
# Verilator build of the DMA subsystem testbench

VERILATOR       ?= verilator
TOP             ?= dma_tb
FILELIST        ?= compile.f
OBJ_DIR         ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT       ?= All tests passed

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv tb/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
+incdir+include
hdl/dma_pkg.sv
hdl/byte_fifo.sv
hdl/credit_sender.sv
hdl/memory_dma.sv
hdl/half_word_ram.sv
hdl/dma_subsystem.sv
tb/dma_checker.sv
tb/dma_tb.sv

/* hdl/byte_fifo.sv */
`include "dma_config.svh"

module byte_fifo (
    input  logic           clk,
    input  logic           reset,
    input  logic           write,
    input  dma_pkg::byte_t wdata,
    output logic           full,
    input  logic           read,
    output dma_pkg::byte_t rdata,
    output logic           empty
);
    import dma_pkg::*;

    localparam int ptr_width = $clog2(`DMA_FIFO_DEPTH);
    localparam int last_slot = `DMA_FIFO_DEPTH - 1;

    byte_t storage [`DMA_FIFO_DEPTH];
    logic [ptr_width - 1:0] wr_ptr;
    logic [ptr_width - 1:0] rd_ptr;
    fifo_count_t count;
    logic do_write;
    logic do_read;

    always_comb begin
        full = count == fifo_count_t'(`DMA_FIFO_DEPTH);
        empty = count == '0;
        do_write = write && !full;
        do_read = read && !empty;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                if (wr_ptr == ptr_width'(last_slot)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_read) begin
                if (rd_ptr == ptr_width'(last_slot)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

    // the popped byte sits in the output register until the next pop
    always_ff @(posedge clk) begin
        if (do_write) begin
            storage[wr_ptr] <= wdata;
        end
        if (do_read) begin
            rdata <= storage[rd_ptr];
        end
    end

endmodule

/* hdl/credit_sender.sv */
`include "dma_config.svh"

module credit_sender (
    input  logic           clk,
    input  logic           reset,
    input  logic           fifo_empty,
    output logic           fifo_read,
    input  dma_pkg::byte_t fifo_rdata,
    input  logic           credit_return,
    output logic           tx_valid,
    output dma_pkg::byte_t tx_data
);
    import dma_pkg::*;

    credit_t credits;

    // tx_valid doubles as the read-in-flight flag
    always_comb begin
        fifo_read = (credits != '0) && !tx_valid && !fifo_empty;
        tx_data = fifo_rdata;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= credit_t'(`DMA_TX_CREDITS);
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= fifo_read;
            if (fifo_read && !credit_return) begin
                credits <= credits - 1'b1;
            end else if (credit_return && !fifo_read) begin
                credits <= credits + 1'b1;
            end
        end
    end

endmodule

/* hdl/dma_pkg.sv */
`include "dma_config.svh"

package dma_pkg;

    // one stream byte and one memory word
    typedef logic [7:0] byte_t;
    typedef logic [15:0] half_t;

    // byte address or byte count
    typedef logic [`DMA_ADDR_WIDTH - 1:0] addr_t;

    // bit 1 enables the high byte, which is the even address
    typedef logic [1:0] wmask_t;

    typedef logic [$clog2(`DMA_FIFO_DEPTH + 1) - 1:0] credit_t;
    typedef logic [$clog2(`DMA_FIFO_DEPTH + 1) - 1:0] fifo_count_t;

endpackage

/* hdl/dma_subsystem.sv */
module dma_subsystem (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  logic           stop,
    input  logic           direction,
    input  logic           byte_swap,
    input  dma_pkg::addr_t starting_address,
    input  dma_pkg::addr_t transfer_length,
    output logic           busy,
    input  logic           rx_valid,
    input  dma_pkg::byte_t rx_data,
    output logic           rx_credit,
    output logic           tx_valid,
    output dma_pkg::byte_t tx_data,
    input  logic           tx_credit_return
);
    import dma_pkg::*;

    logic rx_empty;
    byte_t rx_rdata;
    logic tx_full;
    logic tx_write;
    byte_t tx_wdata;
    logic tx_empty;
    logic tx_read;
    byte_t tx_rdata;

    logic mem_request;
    logic mem_write;
    addr_t mem_address;
    wmask_t mem_wmask;
    half_t mem_wdata;
    logic mem_ack;
    half_t mem_rdata;

    // the rx sender holds one credit per FIFO slot, so full is never reached
    byte_fifo rx_fifo_i (
        .clk   (clk),
        .reset (reset),
        .write (rx_valid),
        .wdata (rx_data),
        .full  (),
        .read  (rx_credit),
        .rdata (rx_rdata),
        .empty (rx_empty)
    );

    byte_fifo tx_fifo_i (
        .clk   (clk),
        .reset (reset),
        .write (tx_write),
        .wdata (tx_wdata),
        .full  (tx_full),
        .read  (tx_read),
        .rdata (tx_rdata),
        .empty (tx_empty)
    );

    credit_sender credit_sender_i (
        .clk           (clk),
        .reset         (reset),
        .fifo_empty    (tx_empty),
        .fifo_read     (tx_read),
        .fifo_rdata    (tx_rdata),
        .credit_return (tx_credit_return),
        .tx_valid      (tx_valid),
        .tx_data       (tx_data)
    );

    memory_dma memory_dma_i (
        .clk              (clk),
        .reset            (reset),
        .start            (start),
        .stop             (stop),
        .direction        (direction),
        .byte_swap        (byte_swap),
        .starting_address (starting_address),
        .transfer_length  (transfer_length),
        .busy             (busy),
        .rx_empty         (rx_empty),
        .rx_read          (rx_credit),
        .rx_rdata         (rx_rdata),
        .tx_full          (tx_full),
        .tx_write         (tx_write),
        .tx_wdata         (tx_wdata),
        .mem_request      (mem_request),
        .mem_write        (mem_write),
        .mem_address      (mem_address),
        .mem_wmask        (mem_wmask),
        .mem_wdata        (mem_wdata),
        .mem_ack          (mem_ack),
        .mem_rdata        (mem_rdata)
    );

    half_word_ram half_word_ram_i (
        .clk     (clk),
        .reset   (reset),
        .request (mem_request),
        .write   (mem_write),
        .address (mem_address),
        .wmask   (mem_wmask),
        .wdata   (mem_wdata),
        .ack     (mem_ack),
        .rdata   (mem_rdata)
    );

endmodule

/* hdl/half_word_ram.sv */
`include "dma_config.svh"

module half_word_ram (
    input  logic            clk,
    input  logic            reset,
    input  logic            request,
    input  logic            write,
    input  dma_pkg::addr_t  address,
    input  dma_pkg::wmask_t wmask,
    input  dma_pkg::half_t  wdata,
    output logic            ack,
    output dma_pkg::half_t  rdata
);
    import dma_pkg::*;

    localparam int idx_width = $clog2(`DMA_MEM_WORDS);
    localparam int lat_width = $clog2(`DMA_MEM_LATENCY + 1);

    half_t mem_array [`DMA_MEM_WORDS];
    logic [idx_width - 1:0] index;
    logic [lat_width - 1:0] elapsed;
    logic active;
    logic hold;
    logic due;

    // byte address bit 0 selects the lane, so the word index starts at bit 1
    always_comb begin
        index = address[idx_width:1];
        due = active && (elapsed == lat_width'(`DMA_MEM_LATENCY - 1));
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            hold <= 1'b0;
            ack <= 1'b0;
            elapsed <= '0;
        end else begin
            ack <= due;
            if (!request) begin
                hold <= 1'b0;
            end
            if (due) begin
                active <= 1'b0;
                hold <= 1'b1;
            end else if (active) begin
                elapsed <= elapsed + 1'b1;
            end else if (request && !hold) begin
                active <= 1'b1;
                elapsed <= lat_width'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (due && write) begin
            if (wmask[1]) begin
                mem_array[index][15:8] <= wdata[15:8];
            end
            if (wmask[0]) begin
                mem_array[index][7:0] <= wdata[7:0];
            end
        end
        if (due && !write) begin
            rdata <= mem_array[index];
        end
    end

endmodule

/* hdl/memory_dma.sv */
module memory_dma (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  logic            stop,
    input  logic            direction,
    input  logic            byte_swap,
    input  dma_pkg::addr_t  starting_address,
    input  dma_pkg::addr_t  transfer_length,
    output logic            busy,
    input  logic            rx_empty,
    output logic            rx_read,
    input  dma_pkg::byte_t  rx_rdata,
    input  logic            tx_full,
    output logic            tx_write,
    output dma_pkg::byte_t  tx_wdata,
    output logic            mem_request,
    output logic            mem_write,
    output dma_pkg::addr_t  mem_address,
    output dma_pkg::wmask_t mem_wmask,
    output dma_pkg::half_t  mem_wdata,
    input  logic            mem_ack,
    input  dma_pkg::half_t  mem_rdata
);
    import dma_pkg::*;

    logic accept;
    logic running;
    addr_t remaining;
    logic swap_q;

    logic pop_pending;
    logic byte_odd;
    logic lane_high;
    logic last_byte;
    half_t wr_buffer;
    wmask_t wr_mask;
    logic wr_ready;
    logic wr_issue;

    half_t rd_word;
    logic [1:0] rd_left;
    logic rd_skip;
    logic rd_fetch;

    // **************************************************
    // control and byte count
    // **************************************************

    always_comb begin
        accept = start && !stop && !busy;
        running = (remaining != '0) && !stop;
        busy = (remaining != '0) || mem_request || pop_pending || wr_ready;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            remaining <= '0;
            mem_write <= 1'b0;
            swap_q <= 1'b0;
        end else if (stop) begin
            remaining <= '0;
        end else if (accept) begin
            remaining <= transfer_length;
            mem_write <= direction;
            swap_q <= byte_swap;
        end else if (rx_read || tx_write) begin
            remaining <= remaining - addr_t'(1);
        end
    end

    // **************************************************
    // write path, rx bytes into masked half-words
    // **************************************************

    // with swap the two lanes of a half-word trade places
    always_comb begin
        rx_read = mem_write && running && !rx_empty && !pop_pending && !wr_ready;
        lane_high = byte_odd == swap_q;
        last_byte = byte_odd || (remaining == '0);
        wr_issue = wr_ready && mem_write && !mem_request && !stop;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pop_pending <= 1'b0;
            wr_ready <= 1'b0;
            wr_mask <= '0;
            byte_odd <= 1'b0;
        end else if (stop) begin
            // a byte still in flight is dropped
            pop_pending <= 1'b0;
            wr_ready <= 1'b0;
            wr_mask <= '0;
        end else begin
            pop_pending <= rx_read;
            if (accept) begin
                byte_odd <= starting_address[0];
                wr_mask <= '0;
            end
            if (pop_pending) begin
                byte_odd <= !byte_odd;
                if (lane_high) begin
                    wr_mask[1] <= 1'b1;
                end else begin
                    wr_mask[0] <= 1'b1;
                end
                wr_ready <= last_byte;
            end
            if (wr_issue) begin
                wr_ready <= 1'b0;
                wr_mask <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop_pending) begin
            if (lane_high) begin
                wr_buffer[15:8] <= rx_rdata;
            end else begin
                wr_buffer[7:0] <= rx_rdata;
            end
        end
    end

    // **************************************************
    // read path, half-words out as tx bytes
    // **************************************************

    always_comb begin
        rd_fetch = !mem_write && running && !mem_request && (rd_left == 2'd0);
        tx_write = !mem_write && running && (rd_left != 2'd0) && !tx_full;
        tx_wdata = (rd_left == 2'd2) ? rd_word[15:8] : rd_word[7:0];
    end

    // an odd first address leaves only the low byte of the first word
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_left <= 2'd0;
            rd_skip <= 1'b0;
        end else if (stop) begin
            rd_left <= 2'd0;
        end else if (accept) begin
            rd_left <= 2'd0;
            rd_skip <= starting_address[0];
        end else if (mem_ack && !mem_write) begin
            rd_left <= rd_skip ? 2'd1 : 2'd2;
            rd_skip <= 1'b0;
        end else if (tx_write) begin
            rd_left <= rd_left - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_ack) begin
            rd_word <= mem_rdata;
        end
    end

    // **************************************************
    // memory bus
    // **************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_request <= 1'b0;
        end else if (mem_ack) begin
            mem_request <= 1'b0;
        end else if (wr_issue || rd_fetch) begin
            mem_request <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mem_address <= starting_address & ~addr_t'(1);
        end else if (mem_ack) begin
            mem_address <= mem_address + addr_t'(2);
        end
        if (wr_issue) begin
            mem_wdata <= wr_buffer;
            mem_wmask <= wr_mask;
        end
    end

endmodule

/* include/dma_config.svh */
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// byte address and byte count width
`define DMA_ADDR_WIDTH 27

// entries in each byte FIFO, also the credits the rx sender starts with
`define DMA_FIFO_DEPTH 8

// credits the tx consumer grants at reset
`define DMA_TX_CREDITS 4

// half-words in the on-chip RAM
`define DMA_MEM_WORDS 256

// cycles from an accepted request to its ack
`define DMA_MEM_LATENCY 3

`endif

/* tb/dma_checker.sv */
`include "dma_config.svh"

module dma_checker (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  logic           stop,
    input  logic           direction,
    input  logic           byte_swap,
    input  dma_pkg::addr_t starting_address,
    input  dma_pkg::addr_t transfer_length,
    input  logic           busy,
    input  logic           rx_valid,
    input  dma_pkg::byte_t rx_data,
    input  logic           rx_credit,
    input  logic           tx_valid,
    input  dma_pkg::byte_t tx_data,
    input  logic           tx_credit_return,
    input  int             test_id,
    input  logic           test_end,
    output int             error_count,
    output int             failed_tests
);
    timeunit 1ns;
    timeprecision 1ps;
    import dma_pkg::*;

    localparam int model_bytes = 2 * `DMA_MEM_WORDS;
    localparam int stop_bound = `DMA_MEM_LATENCY + 4;

    // byte-wide image of the RAM, big-endian within each half-word
    byte_t model [model_bytes];
    bit known [model_bytes];

    logic xfer_write;
    logic xfer_swap;
    int xfer_addr;
    int xfer_len;
    int wr_index;
    int rd_index;
    int popped;
    logic aborted;
    logic rise_due;
    int stop_cycles;
    logic busy_q;
    int tx_balance;
    int errors_at_start;

    function automatic string test_name(input int id);
        case (id)
            1: return "aligned_write_read";
            2: return "odd_start_odd_length";
            3: return "byte_swap_write";
            4: return "tx_back_pressure";
            5: return "ignored_start_and_stop";
            default: return "setup";
        endcase
    endfunction

    // with swap each byte lands on the other lane of its half-word
    function automatic int write_slot(input int index);
        int slot;
        slot = (xfer_addr + index) % model_bytes;
        if (xfer_swap) begin
            slot = slot ^ 1;
        end
        return slot;
    endfunction

    task automatic report_error(input string text);
        $display("ERROR %s: %s", test_name(test_id), text);
        error_count++;
    endtask

    // **************************************************
    // transfer tracking and byte comparison
    // **************************************************

    always @(posedge clk) begin
        int addr;
        int i;
        if (reset) begin
            xfer_write = 1'b0;
            xfer_swap = 1'b0;
            xfer_addr = 0;
            xfer_len = 0;
            wr_index = 0;
            rd_index = 0;
            popped = 0;
            aborted = 1'b0;
            rise_due = 1'b0;
            stop_cycles = 0;
            busy_q = 1'b0;
            tx_balance = `DMA_TX_CREDITS;
            error_count = 0;
            failed_tests = 0;
            errors_at_start = 0;
        end else begin
            if (rise_due && !busy) begin
                report_error("busy did not rise after an accepted start");
            end
            rise_due = 1'b0;

            if (aborted && busy) begin
                stop_cycles++;
                if (stop_cycles == stop_bound) begin
                    report_error("busy is still high long after stop");
                end
            end

            // what an aborted write left in memory is not defined
            if (stop && busy && !aborted) begin
                aborted = 1'b1;
                stop_cycles = 0;
                if (xfer_write) begin
                    for (i = 0; i < xfer_len; i++) begin
                        known[write_slot(i)] = 1'b0;
                    end
                end
            end

            if (start && !stop && !busy) begin
                xfer_write = direction;
                xfer_swap = byte_swap;
                xfer_addr = int'(starting_address);
                xfer_len = int'(transfer_length);
                wr_index = 0;
                rd_index = 0;
                popped = 0;
                aborted = 1'b0;
                rise_due = transfer_length != '0;
            end

            if (rx_credit) begin
                if (aborted) begin
                    report_error("an rx byte was popped after stop");
                end
                popped++;
            end

            if (busy_q && !busy && xfer_write && !aborted && popped != xfer_len) begin
                report_error($sformatf("write ended after %0d of %0d bytes", popped, xfer_len));
            end

            if (rx_valid) begin
                if (!xfer_write || aborted) begin
                    report_error("an rx byte was sent outside a write transfer");
                end else begin
                    addr = write_slot(wr_index);
                    model[addr] = rx_data;
                    known[addr] = 1'b1;
                    wr_index++;
                end
            end

            if (tx_valid) begin
                tx_balance--;
                if (tx_balance < 0) begin
                    report_error("tx_valid pulsed with no credit left");
                end
                if (xfer_write || rd_index >= xfer_len) begin
                    report_error("a tx byte arrived that no read transfer asked for");
                end else begin
                    addr = (xfer_addr + rd_index) % model_bytes;
                    if (!known[addr]) begin
                        report_error($sformatf("read of address 0x%03h, never written", addr));
                    end else if (tx_data !== model[addr]) begin
                        report_error($sformatf(
                            "tx byte %0d at address 0x%03h expected 0x%02h actual 0x%02h",
                            rd_index, addr, model[addr], tx_data));
                    end
                    rd_index++;
                end
            end
            if (tx_credit_return) begin
                tx_balance++;
            end

            if (test_end) begin
                if (error_count == errors_at_start) begin
                    $display("test %0d %s: passed", test_id, test_name(test_id));
                end else begin
                    failed_tests++;
                    $display("test %0d %s: failed with %0d errors", test_id,
                             test_name(test_id), error_count - errors_at_start);
                end
                errors_at_start = error_count;
            end

            busy_q = busy;
        end
    end

endmodule

/* tb/dma_tb.sv */
`include "dma_config.svh"

module dma_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import dma_pkg::*;

    localparam int half_period = 10;
    localparam int clk_period = 2 * half_period;
    localparam int drive_delay = 2;
    localparam int test_count = 5;

    localparam int t1_addr = 'h010;
    localparam int t1_len = 16;
    localparam int t2_addr = 'h013;
    localparam int t2_len = 9;
    localparam int t3_addr = 'h040;
    localparam int t3_len = 12;
    localparam int t4_addr = 'h080;
    localparam int t4_len = 96;
    localparam int t5_addr = 'h100;
    localparam int t5_len = 24;
    localparam int abort_addr = 'h140;
    localparam int abort_len = 20;
    localparam int abort_sent = 6;
    localparam int fresh_addr = 'h160;
    localparam int fresh_len = 6;

    // test 2 reads its own region, then one neighbor byte more on each side
    localparam int total_bytes = 2 * t1_len + 2 * t2_len + (t2_len + 2) + 2 * t3_len
                               + 2 * t4_len + 2 * t5_len + abort_sent + 2 * fresh_len;
    localparam int per_byte_cycles = 60;
    localparam int margin_cycles = 1000;
    localparam int watchdog_cycles = total_bytes * per_byte_cycles + margin_cycles;

    logic clk = 1'b0;
    logic reset;
    logic start;
    logic stop;
    logic direction;
    logic byte_swap;
    addr_t starting_address;
    addr_t transfer_length;
    logic busy;
    logic rx_valid = 1'b0;
    byte_t rx_data = '0;
    logic rx_credit;
    logic tx_valid;
    byte_t tx_data;
    logic tx_credit_return = 1'b0;

    int test_id;
    logic test_end;
    int error_count;
    int failed_tests;

    byte_t rx_queue[$];
    int rx_credits;
    int rx_popped = 0;
    int tx_owed;
    int tx_hold;
    int tx_received = 0;
    bit stall_mode = 1'b0;

    always #half_period clk = !clk;

    dma_subsystem dma_subsystem_i (
        .clk              (clk),
        .reset            (reset),
        .start            (start),
        .stop             (stop),
        .direction        (direction),
        .byte_swap        (byte_swap),
        .starting_address (starting_address),
        .transfer_length  (transfer_length),
        .busy             (busy),
        .rx_valid         (rx_valid),
        .rx_data          (rx_data),
        .rx_credit        (rx_credit),
        .tx_valid         (tx_valid),
        .tx_data          (tx_data),
        .tx_credit_return (tx_credit_return)
    );

    dma_checker checker_i (
        .clk              (clk),
        .reset            (reset),
        .start            (start),
        .stop             (stop),
        .direction        (direction),
        .byte_swap        (byte_swap),
        .starting_address (starting_address),
        .transfer_length  (transfer_length),
        .busy             (busy),
        .rx_valid         (rx_valid),
        .rx_data          (rx_data),
        .rx_credit        (rx_credit),
        .tx_valid         (tx_valid),
        .tx_data          (tx_data),
        .tx_credit_return (tx_credit_return),
        .test_id          (test_id),
        .test_end         (test_end),
        .error_count      (error_count),
        .failed_tests     (failed_tests)
    );

    // **************************************************
    // stream drivers
    // **************************************************

    // the rx sender spends one credit per byte and gets one back per FIFO pop
    always @(posedge clk) begin
        logic send_now;
        send_now = 1'b0;
        if (reset) begin
            rx_credits = `DMA_FIFO_DEPTH;
        end else begin
            if (rx_credit) begin
                rx_credits++;
                rx_popped++;
            end
            send_now = (rx_credits > 0) && (rx_queue.size() != 0);
            if (send_now) begin
                rx_credits--;
            end
        end
        #drive_delay;
        rx_valid = send_now;
        if (send_now) begin
            rx_data = rx_queue.pop_front();
        end
    end

    // the tx consumer hands back one credit per byte after a random hold-off
    always @(posedge clk) begin
        logic give;
        give = 1'b0;
        if (reset) begin
            tx_owed = 0;
            tx_hold = 0;
        end else begin
            if (tx_valid) begin
                tx_owed++;
                tx_received++;
            end
            if (tx_hold > 0) begin
                tx_hold--;
            end else if (tx_owed > 0) begin
                give = 1'b1;
                tx_owed--;
                if (stall_mode && $urandom_range(3) == 0) begin
                    tx_hold = $urandom_range(40);
                end else begin
                    tx_hold = $urandom_range(2);
                end
            end
        end
        #drive_delay;
        tx_credit_return = give;
    end

    // **************************************************
    // test sequence
    // **************************************************

    task automatic next_cycle();
        @(posedge clk);
        #drive_delay;
    endtask

    task automatic issue_start(input logic write_dir, input logic swap, input int addr,
                               input int len);
        next_cycle();
        start = 1'b1;
        direction = write_dir;
        byte_swap = swap;
        starting_address = addr_t'(addr);
        transfer_length = addr_t'(len);
        next_cycle();
        start = 1'b0;
    endtask

    task automatic issue_stop();
        next_cycle();
        stop = 1'b1;
        next_cycle();
        stop = 1'b0;
    endtask

    task automatic wait_idle();
        while (busy) begin
            next_cycle();
        end
    endtask

    task automatic start_write(input int addr, input int len, input int sent, input logic swap);
        int i;
        issue_start(1'b1, swap, addr, len);
        for (i = 0; i < sent; i++) begin
            rx_queue.push_back(byte_t'($urandom));
        end
    endtask

    task automatic write_block(input int addr, input int len, input logic swap);
        start_write(addr, len, len, swap);
        wait_idle();
    endtask

    // the read is over once every byte has left through the credit stream
    task automatic read_block(input int addr, input int len);
        int target;
        target = tx_received + len;
        issue_start(1'b0, 1'b0, addr, len);
        wait_idle();
        while (tx_received < target) begin
            next_cycle();
        end
    endtask

    task automatic end_test();
        test_end = 1'b1;
        next_cycle();
        test_end = 1'b0;
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        $display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int seed_value;
        int popped_target;
        seed_value = $urandom(45);
        reset = 1'b1;
        start = 1'b0;
        stop = 1'b0;
        direction = 1'b0;
        byte_swap = 1'b0;
        starting_address = '0;
        transfer_length = '0;
        test_id = 0;
        test_end = 1'b0;
        repeat (3) @(posedge clk);
        #drive_delay;
        reset = 1'b0;

        test_id = 1;
        write_block(t1_addr, t1_len, 1'b0);
        read_block(t1_addr, t1_len);
        end_test();

        test_id = 2;
        write_block(t2_addr, t2_len, 1'b0);
        read_block(t2_addr, t2_len);
        read_block(t2_addr - 1, t2_len + 2);
        end_test();

        test_id = 3;
        write_block(t3_addr, t3_len, 1'b1);
        read_block(t3_addr, t3_len);
        end_test();

        test_id = 4;
        write_block(t4_addr, t4_len, 1'b0);
        stall_mode = 1'b1;
        read_block(t4_addr, t4_len);
        stall_mode = 1'b0;
        end_test();

        // a second start lands while the write is still running
        test_id = 5;
        start_write(t5_addr, t5_len, t5_len, 1'b0);
        repeat (4) next_cycle();
        issue_start(1'b0, 1'b0, 'h1f0, 3);
        wait_idle();
        read_block(t5_addr, t5_len);
        popped_target = rx_popped + abort_sent;
        start_write(abort_addr, abort_len, abort_sent, 1'b0);
        while (rx_popped < popped_target) begin
            next_cycle();
        end
        issue_stop();
        wait_idle();
        write_block(fresh_addr, fresh_len, 1'b0);
        read_block(fresh_addr, fresh_len);
        end_test();

        repeat (2) next_cycle();
        $display("tests run: %0d, tests failed: %0d, errors: %0d", test_count, failed_tests,
                 error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
